/* filelist.f */
+incdir+.
opf_inst_pkg.sv
opf_data_pkg.sv
reg_bank_2r1w.sv
register_files.sv
fetch_pipeline_ctrl.sv
operand_select.sv
operand_fetch.sv
tb_operand_fetch.sv

/* Bender.yml */
package:
  name: operand_fetch

export_include_dirs:
  - .

sources:
  - opf_inst_pkg.sv
  - opf_data_pkg.sv
  - reg_bank_2r1w.sv
  - register_files.sv
  - fetch_pipeline_ctrl.sv
  - operand_select.sv
  - operand_fetch.sv
  - target: test
    files:
      - tb_operand_fetch.sv

/* opf_ref_model.svh */
`ifndef OPF_REF_MODEL_SVH
`define OPF_REF_MODEL_SVH

// one expected output beat
typedef struct {
	opf_inst_pkg::thread_id_t   thread;
	opf_inst_pkg::instruction_t inst;
	opf_data_pkg::hw_lane_t     op0;
	opf_data_pkg::hw_lane_t     op1;
	opf_data_pkg::lane_mask_t   mask;
	opf_inst_pkg::scoreboard_t  bitmap;
} expect_t;

// shadow register files indexed by thread then register
opf_data_pkg::register_t shadow_scalar [`OPF_THREAD_NUMB][`OPF_REG_NUMBER];
opf_data_pkg::hw_lane_t  shadow_vector [`OPF_THREAD_NUMB][`OPF_REG_NUMBER];

// byte masked writeback
// scalars take lane 0 of the data, vectors only the enabled lanes
function automatic void shadow_write(
	input int                       t,
	input int                       r,
	input logic                     is_scalar,
	input opf_data_pkg::byte_en_t   be,
	input opf_data_pkg::lane_mask_t lanes,
	input opf_data_pkg::hw_lane_t   data
);
	for (int b = 0; b < `OPF_BYTE_PER_REG; b++) begin
		if (be[b] && is_scalar) begin
			shadow_scalar[t][r][b*8 +: 8] = data[0][b*8 +: 8];
		end
		for (int l = 0; l < `OPF_HW_LANE; l++) begin
			if (be[b] && !is_scalar && lanes[l]) begin
				shadow_vector[t][r][l][b*8 +: 8] = data[l][b*8 +: 8];
			end
		end
	end
endfunction

// expected output of one instruction from the shadow files
function automatic expect_t predict(
	input opf_inst_pkg::thread_id_t   t,
	input opf_inst_pkg::instruction_t inst,
	input opf_inst_pkg::scoreboard_t  bitmap
);
	expect_t                 e;
	opf_data_pkg::register_t base;
	opf_data_pkg::register_t word1;
	logic                    pc1;
	// pc number as source0 stands for the instruction pc
	base = (inst.source0 == `OPF_PC_REG) ? inst.pc : shadow_scalar[t][inst.source0];
	pc1 = inst.source1 == `OPF_PC_REG;
	// masked instructions see the mask register on the scalar side
	word1 = shadow_scalar[t][inst.mask_enable ? `OPF_MASK_REG : inst.source1];
	e.thread = t;
	e.inst = inst;
	e.bitmap = bitmap;
	for (int l = 0; l < `OPF_HW_LANE; l++) begin
		if (inst.is_source0_vectorial) begin
			e.op0[l] = shadow_vector[t][inst.source0][l];
		end else if (inst.is_memory_access) begin
			e.op0[l] = base + inst.immediate;
		end else begin
			e.op0[l] = base;
		end
		if (inst.is_source1_immediate) begin
			e.op1[l] = inst.immediate;
		end else if (inst.is_source1_vectorial) begin
			e.op1[l] = shadow_vector[t][inst.source1][l];
		end else if (pc1) begin
			e.op1[l] = inst.pc;
		end else begin
			e.op1[l] = word1;
		end
	end
	e.mask = inst.mask_enable ? shadow_scalar[t][`OPF_MASK_REG][`OPF_HW_LANE-1:0] : '1;
	return e;
endfunction

`endif

/* tb_operand_fetch.sv */
`timescale 1ns/1ps
`include "opf_consts.svh"

module tb_operand_fetch;

	localparam int RUN_CYCLES = 3000;
	localparam int HOLD_LIMIT = 200;
	localparam int DRAIN_LIMIT = 50;
	// bits of one preload index
	localparam int PRELOAD_W = $bits(opf_inst_pkg::thread_id_t) +
		$bits(opf_inst_pkg::reg_addr_t) + 1;

	logic                        clk;
	logic                        reset;
	logic                        issue_valid;
	logic                        issue_ready;
	opf_inst_pkg::thread_id_t    issue_thread;
	opf_inst_pkg::instruction_t  issue_inst;
	opf_inst_pkg::scoreboard_t   issue_dest_bitmap;
	logic                        opf_valid;
	logic                        opf_ready;
	opf_inst_pkg::instruction_t  opf_inst;
	opf_data_pkg::hw_lane_t      opf_op0;
	opf_data_pkg::hw_lane_t      opf_op1;
	opf_data_pkg::lane_mask_t    opf_lane_mask;
	opf_inst_pkg::scoreboard_t   opf_dest_bitmap;
	logic                        wb_valid;
	opf_inst_pkg::thread_id_t    wb_thread;
	opf_inst_pkg::reg_addr_t     wb_reg;
	logic                        wb_is_scalar;
	opf_data_pkg::byte_en_t      wb_byte_en;
	opf_data_pkg::lane_mask_t    wb_lane_mask;
	opf_data_pkg::hw_lane_t      wb_data;
	logic [`OPF_THREAD_NUMB-1:0] rollback;

	`include "opf_ref_model.svh"

	// model pipeline with out_q mirroring the output register
	expect_t     out_q [$];
	expect_t     s1_entry;
	logic        s1_full;
	logic        accepted;
	int          hold_cycles;

	operand_fetch u_operand_fetch (
		.clk               (clk),
		.reset             (reset),
		.issue_valid       (issue_valid),
		.issue_ready       (issue_ready),
		.issue_thread      (issue_thread),
		.issue_inst        (issue_inst),
		.issue_dest_bitmap (issue_dest_bitmap),
		.opf_valid         (opf_valid),
		.opf_ready         (opf_ready),
		.opf_inst          (opf_inst),
		.opf_op0           (opf_op0),
		.opf_op1           (opf_op1),
		.opf_lane_mask     (opf_lane_mask),
		.opf_dest_bitmap   (opf_dest_bitmap),
		.wb_valid          (wb_valid),
		.wb_thread         (wb_thread),
		.wb_reg            (wb_reg),
		.wb_is_scalar      (wb_is_scalar),
		.wb_byte_en        (wb_byte_en),
		.wb_lane_mask      (wb_lane_mask),
		.wb_data           (wb_data),
		.rollback          (rollback)
	);

	always #10 clk = ~clk;

	task automatic abort_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic report_mismatch(input string what);
		$display("** Error at %0t ns: %s does not match the model", $time, what);
		abort_with_failure();
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		abort_with_failure();
	endtask

	// pc and mask register numbers come up often
	function automatic opf_inst_pkg::reg_addr_t pick_reg();
		case ($urandom_range(0, 7))
			0: return opf_inst_pkg::reg_addr_t'(`OPF_PC_REG);
			1: return opf_inst_pkg::reg_addr_t'(`OPF_MASK_REG);
			default: return opf_inst_pkg::reg_addr_t'($urandom);
		endcase
	endfunction

	// output compared every valid cycle, so a stall must hold it
	task automatic check_output();
		expect_t head;
		assert (opf_valid === (out_q.size() != 0)) else report_mismatch("opf_valid");
		if (opf_valid) begin
			head = out_q[0];
			assert (opf_inst == head.inst) else report_mismatch("opf_inst");
			assert (opf_op0 == head.op0) else report_mismatch("opf_op0");
			assert (opf_op1 == head.op1) else report_mismatch("opf_op1");
			assert (opf_lane_mask == head.mask) else report_mismatch("opf_lane_mask");
			assert (opf_dest_bitmap == head.bitmap) else report_mismatch("opf_dest_bitmap");
		end
	endtask

	// sample before the edge, update the model for it, return 2 ns after it
	task automatic model_edge();
		logic adv;
		@(negedge clk);
		check_output();
		adv = out_q.size() == 0 || opf_ready;
		assert (issue_ready === adv) else report_mismatch("issue_ready");
		accepted = issue_valid && adv;
		if (adv) begin
			// consumer takes the output beat
			if (out_q.size() != 0) begin
				out_q.delete(0);
			end
			// stage 1 to output step is the second squash point
			if (s1_full && !rollback[s1_entry.thread]) begin
				out_q.push_back(s1_entry);
			end
			// reads see the files before this edge's write
			s1_full = accepted && !rollback[issue_thread];
			if (s1_full) begin
				s1_entry = predict(issue_thread, issue_inst, issue_dest_bitmap);
			end
		end
		if (wb_valid) begin
			shadow_write(wb_thread, wb_reg, wb_is_scalar, wb_byte_en, wb_lane_mask, wb_data);
		end
		@(posedge clk);
		#2;
	endtask

	// new instruction only once the previous one is taken
	task automatic drive_issue();
		if (!issue_valid || accepted) begin
			issue_valid = $urandom_range(0, 3) != 0;
			issue_thread = opf_inst_pkg::thread_id_t'($urandom);
			issue_inst.pc = $urandom;
			issue_inst.source0 = pick_reg();
			issue_inst.source1 = pick_reg();
			issue_inst.immediate = $urandom;
			{issue_inst.is_source0_vectorial, issue_inst.is_source1_vectorial,
				issue_inst.is_source1_immediate, issue_inst.mask_enable,
				issue_inst.is_memory_access} = 5'($urandom);
			issue_dest_bitmap = {$urandom, $urandom};
			hold_cycles = 0;
		end else begin
			hold_cycles++;
			if (hold_cycles > HOLD_LIMIT) begin
				stop_run("issued instruction was never accepted");
			end
		end
	endtask

	// back-pressure, rare rollback pulses and random writeback
	task automatic drive_misc();
		opf_ready = $urandom_range(0, 3) != 0;
		rollback = '0;
		if ($urandom_range(0, 9) == 0) begin
			rollback[$urandom_range(0, `OPF_THREAD_NUMB-1)] = 1'b1;
		end
		wb_valid = $urandom_range(0, 1) != 0;
		wb_thread = opf_inst_pkg::thread_id_t'($urandom);
		wb_reg = pick_reg();
		wb_is_scalar = $urandom_range(0, 1) != 0;
		wb_byte_en = opf_data_pkg::byte_en_t'($urandom);
		wb_lane_mask = opf_data_pkg::lane_mask_t'($urandom);
		for (int l = 0; l < `OPF_HW_LANE; l++) begin
			wb_data[l] = $urandom;
		end
	endtask

	initial begin
		int unsigned seed_value;
		int          drain;
		seed_value = $urandom(32'h19feeef8);
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_thread = '0;
		issue_inst = '0;
		issue_dest_bitmap = '0;
		opf_ready = 1'b1;
		wb_valid = 1'b0;
		wb_thread = '0;
		wb_reg = '0;
		wb_is_scalar = 1'b0;
		wb_byte_en = '0;
		wb_lane_mask = '0;
		wb_data = '0;
		rollback = '0;
		s1_full = 1'b0;
		accepted = 1'b0;
		hold_cycles = 0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		// preload every byte of both files of every thread
		wb_valid = 1'b1;
		wb_byte_en = '1;
		wb_lane_mask = '1;
		for (int i = 0; i < 2 * `OPF_THREAD_NUMB * `OPF_REG_NUMBER; i++) begin
			{wb_thread, wb_reg, wb_is_scalar} = PRELOAD_W'(i);
			for (int l = 0; l < `OPF_HW_LANE; l++) begin
				wb_data[l] = $urandom;
			end
			model_edge();
		end
		repeat (RUN_CYCLES) begin
			drive_issue();
			drive_misc();
			model_edge();
		end
		// drain with the consumer always ready
		opf_ready = 1'b1;
		wb_valid = 1'b0;
		rollback = '0;
		for (drain = 0; drain < DRAIN_LIMIT; drain++) begin
			if (accepted) begin
				issue_valid = 1'b0;
			end
			if (!issue_valid && !s1_full && out_q.size() == 0) begin
				break;
			end
			model_edge();
		end
		if (!issue_valid && !s1_full && out_q.size() == 0 && !opf_valid) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_run("pipeline did not drain before the timeout");
		end
	end

endmodule

/* operand_fetch.sv */
`timescale 1ns/1ps
`include "opf_consts.svh"

module operand_fetch (
	input  logic                        clk,
	input  logic                        reset,
	// issue side
	input  logic                        issue_valid,
	output logic                        issue_ready,
	input  opf_inst_pkg::thread_id_t    issue_thread,
	input  opf_inst_pkg::instruction_t  issue_inst,
	input  opf_inst_pkg::scoreboard_t   issue_dest_bitmap,
	// execution side
	output logic                        opf_valid,
	input  logic                        opf_ready,
	output opf_inst_pkg::instruction_t  opf_inst,
	output opf_data_pkg::hw_lane_t      opf_op0,
	output opf_data_pkg::hw_lane_t      opf_op1,
	output opf_data_pkg::lane_mask_t    opf_lane_mask,
	output opf_inst_pkg::scoreboard_t   opf_dest_bitmap,
	// writeback has no ready and is never stalled
	input  logic                        wb_valid,
	input  opf_inst_pkg::thread_id_t    wb_thread,
	input  opf_inst_pkg::reg_addr_t     wb_reg,
	input  logic                        wb_is_scalar,
	input  opf_data_pkg::byte_en_t      wb_byte_en,
	input  opf_data_pkg::lane_mask_t    wb_lane_mask,
	input  opf_data_pkg::hw_lane_t      wb_data,
	// one bit per thread
	input  logic [`OPF_THREAD_NUMB-1:0] rollback
);

	logic                       advance;
	logic                       s1_valid;
	opf_inst_pkg::instruction_t s1_inst;
	opf_inst_pkg::scoreboard_t  s1_dest_bitmap;
	opf_data_pkg::register_t    scalar_rd0;
	opf_data_pkg::register_t    scalar_rd1;
	opf_data_pkg::hw_lane_t     vector_rd0;
	opf_data_pkg::hw_lane_t     vector_rd1;

	// stage 1 reads addressed straight from the issue port
	register_files u_register_files (
		.clk          (clk),
		.advance      (advance),
		.issue_valid  (issue_valid),
		.issue_thread (issue_thread),
		.issue_inst   (issue_inst),
		.wb_valid     (wb_valid),
		.wb_thread    (wb_thread),
		.wb_reg       (wb_reg),
		.wb_is_scalar (wb_is_scalar),
		.wb_byte_en   (wb_byte_en),
		.wb_lane_mask (wb_lane_mask),
		.wb_data      (wb_data),
		.scalar_rd0   (scalar_rd0),
		.scalar_rd1   (scalar_rd1),
		.vector_rd0   (vector_rd0),
		.vector_rd1   (vector_rd1)
	);

	// handshake, squash and stage 1 capture
	fetch_pipeline_ctrl u_fetch_pipeline_ctrl (
		.clk               (clk),
		.reset             (reset),
		.issue_valid       (issue_valid),
		.issue_thread      (issue_thread),
		.issue_inst        (issue_inst),
		.issue_dest_bitmap (issue_dest_bitmap),
		.rollback          (rollback),
		.opf_ready         (opf_ready),
		.issue_ready       (issue_ready),
		.advance           (advance),
		.s1_valid          (s1_valid),
		.s1_thread         (),
		.s1_inst           (s1_inst),
		.s1_dest_bitmap    (s1_dest_bitmap),
		.out_valid         (opf_valid)
	);

	// stage 2 operand forming and output registers
	operand_select u_operand_select (
		.clk             (clk),
		.advance         (advance),
		.s1_valid        (s1_valid),
		.s1_inst         (s1_inst),
		.s1_dest_bitmap  (s1_dest_bitmap),
		.scalar_rd0      (scalar_rd0),
		.scalar_rd1      (scalar_rd1),
		.vector_rd0      (vector_rd0),
		.vector_rd1      (vector_rd1),
		.opf_inst        (opf_inst),
		.opf_op0         (opf_op0),
		.opf_op1         (opf_op1),
		.opf_lane_mask   (opf_lane_mask),
		.opf_dest_bitmap (opf_dest_bitmap)
	);

endmodule

/* operand_select.sv */
`timescale 1ns/1ps
`include "opf_consts.svh"

module operand_select (
	input  logic                       clk,
	input  logic                       advance,
	input  logic                       s1_valid,
	input  opf_inst_pkg::instruction_t s1_inst,
	input  opf_inst_pkg::scoreboard_t  s1_dest_bitmap,
	input  opf_data_pkg::register_t    scalar_rd0,
	input  opf_data_pkg::register_t    scalar_rd1,
	input  opf_data_pkg::hw_lane_t     vector_rd0,
	input  opf_data_pkg::hw_lane_t     vector_rd1,
	output opf_inst_pkg::instruction_t opf_inst,
	output opf_data_pkg::hw_lane_t     opf_op0,
	output opf_data_pkg::hw_lane_t     opf_op1,
	output opf_data_pkg::lane_mask_t   opf_lane_mask,
	output opf_inst_pkg::scoreboard_t  opf_dest_bitmap
);

	logic                     src0_is_pc;
	logic                     src1_is_pc;
	opf_data_pkg::register_t  base0;
	opf_data_pkg::register_t  mem_addr;
	opf_data_pkg::hw_lane_t   op0_d;
	opf_data_pkg::hw_lane_t   op1_d;
	opf_data_pkg::lane_mask_t mask_d;

	// pc register number means the instruction pc
	assign src0_is_pc = s1_inst.source0 == opf_inst_pkg::reg_addr_t'(`OPF_PC_REG);
	assign src1_is_pc = s1_inst.source1 == opf_inst_pkg::reg_addr_t'(`OPF_PC_REG);

	// base of a memory access, pc or scalar
	assign base0 = src0_is_pc ? s1_inst.pc : scalar_rd0;
	assign mem_addr = base0 + s1_inst.immediate;

	// operand 0
	always_comb begin
		if (s1_inst.is_source0_vectorial) begin
			op0_d = vector_rd0;
		end else if (s1_inst.is_memory_access) begin
			// effective address in every lane
			op0_d = {`OPF_HW_LANE{mem_addr}};
		end else if (src0_is_pc) begin
			op0_d = {`OPF_HW_LANE{s1_inst.pc}};
		end else begin
			op0_d = {`OPF_HW_LANE{scalar_rd0}};
		end
	end

	// operand 1, immediate wins over any register
	always_comb begin
		if (s1_inst.is_source1_immediate) begin
			op1_d = {`OPF_HW_LANE{s1_inst.immediate}};
		end else if (s1_inst.is_source1_vectorial) begin
			op1_d = vector_rd1;
		end else if (src1_is_pc) begin
			op1_d = {`OPF_HW_LANE{s1_inst.pc}};
		end else begin
			// masked scalar op1 carries the mask register, port 1 was redirected
			op1_d = {`OPF_HW_LANE{scalar_rd1}};
		end
	end

	// low bits of the mask register, all lanes when unmasked
	assign mask_d = s1_inst.mask_enable ?
		scalar_rd1[`OPF_HW_LANE-1:0] : {`OPF_HW_LANE{1'b1}};

	// output registers, empty slots keep the old payload
	always_ff @(posedge clk) begin
		if (advance && s1_valid) begin
			opf_inst <= s1_inst;
			opf_op0 <= op0_d;
			opf_op1 <= op1_d;
			opf_lane_mask <= mask_d;
			opf_dest_bitmap <= s1_dest_bitmap;
		end
	end

endmodule

/* fetch_pipeline_ctrl.sv */
`timescale 1ns/1ps
`include "opf_consts.svh"

module fetch_pipeline_ctrl (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         issue_valid,
	input  opf_inst_pkg::thread_id_t     issue_thread,
	input  opf_inst_pkg::instruction_t   issue_inst,
	input  opf_inst_pkg::scoreboard_t    issue_dest_bitmap,
	input  logic [`OPF_THREAD_NUMB-1:0]  rollback,
	input  logic                         opf_ready,
	output logic                         issue_ready,
	output logic                         advance,
	output logic                         s1_valid,
	output opf_inst_pkg::thread_id_t     s1_thread,
	output opf_inst_pkg::instruction_t   s1_inst,
	output opf_inst_pkg::scoreboard_t    s1_dest_bitmap,
	output logic                         out_valid
);

	logic issue_kill;
	logic s1_kill;

	// whole pipe moves when the output slot frees up
	assign advance = !out_valid || opf_ready;
	assign issue_ready = advance;

	// rollback of the thread at the step edge
	assign issue_kill = rollback[issue_thread];
	assign s1_kill = rollback[s1_thread];

	// stage 1 and output valid bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= issue_valid && !issue_kill;
			// squashed in stage 1 never reaches the output
			out_valid <= s1_valid && !s1_kill;
		end
	end

	// stage 1 capture, payload only
	always_ff @(posedge clk) begin
		if (advance) begin
			s1_thread <= issue_thread;
			s1_inst <= issue_inst;
			s1_dest_bitmap <= issue_dest_bitmap;
		end
	end

endmodule

/* register_files.sv */
`timescale 1ns/1ps
`include "opf_consts.svh"

module register_files (
	input  logic                       clk,
	input  logic                       advance,
	input  logic                       issue_valid,
	input  opf_inst_pkg::thread_id_t   issue_thread,
	input  opf_inst_pkg::instruction_t issue_inst,
	input  logic                       wb_valid,
	input  opf_inst_pkg::thread_id_t   wb_thread,
	input  opf_inst_pkg::reg_addr_t    wb_reg,
	input  logic                       wb_is_scalar,
	input  opf_data_pkg::byte_en_t     wb_byte_en,
	input  opf_data_pkg::lane_mask_t   wb_lane_mask,
	input  opf_data_pkg::hw_lane_t     wb_data,
	output opf_data_pkg::register_t    scalar_rd0,
	output opf_data_pkg::register_t    scalar_rd1,
	output opf_data_pkg::hw_lane_t     vector_rd0,
	output opf_data_pkg::hw_lane_t     vector_rd1
);

	// read side
	logic                      rd_go;
	logic                      scalar_rd0_en;
	logic                      scalar_rd1_en;
	logic                      vector_rd0_en;
	logic                      vector_rd1_en;
	opf_inst_pkg::reg_addr_t   src1_eff;
	opf_inst_pkg::bank_addr_t  src0_addr;
	opf_inst_pkg::bank_addr_t  scalar_src1_addr;
	opf_inst_pkg::bank_addr_t  vector_src1_addr;

	// write side
	logic                        scalar_wr;
	logic                        vector_wr;
	opf_inst_pkg::bank_addr_t    wr_addr;
	opf_data_pkg::byte_en_t      scalar_byte_en;
	opf_data_pkg::lane_byte_en_t vector_byte_en;

	// reads follow the pipeline step, so outputs hold on a stall
	assign rd_go = advance && issue_valid;

	// port 0 bank picked by source0 flag
	assign scalar_rd0_en = rd_go && !issue_inst.is_source0_vectorial;
	assign vector_rd0_en = rd_go && issue_inst.is_source0_vectorial;
	assign src0_addr = {issue_thread, issue_inst.source0};

	// masked instructions take the scalar port 1 for the mask register
	assign src1_eff = issue_inst.mask_enable ?
		opf_inst_pkg::reg_addr_t'(`OPF_MASK_REG) : issue_inst.source1;
	assign scalar_rd1_en = rd_go &&
		(!issue_inst.is_source1_vectorial || issue_inst.mask_enable);
	assign vector_rd1_en = rd_go && issue_inst.is_source1_vectorial;
	assign scalar_src1_addr = {issue_thread, src1_eff};
	assign vector_src1_addr = {issue_thread, issue_inst.source1};

	// writeback target
	assign scalar_wr = wb_valid && wb_is_scalar;
	assign vector_wr = wb_valid && !wb_is_scalar;
	assign wr_addr = {wb_thread, wb_reg};
	assign scalar_byte_en = wb_byte_en & {`OPF_BYTE_PER_REG{scalar_wr}};

	// per-lane byte enables, lane mask gates whole lanes
	always_comb begin
		for (int l = 0; l < `OPF_HW_LANE; l++) begin
			vector_byte_en[l] = wb_byte_en & {`OPF_BYTE_PER_REG{vector_wr && wb_lane_mask[l]}};
		end
	end

	reg_bank_2r1w #(
		.NB_COL (`OPF_BYTE_PER_REG),
		.word_t (opf_data_pkg::register_t)
	) scalar_bank (
		.clk        (clk),
		.rd0_en     (scalar_rd0_en),
		.rd0_addr   (src0_addr),
		.rd0_data   (scalar_rd0),
		.rd1_en     (scalar_rd1_en),
		.rd1_addr   (scalar_src1_addr),
		.rd1_data   (scalar_rd1),
		.wr_byte_en (scalar_byte_en),
		.wr_addr    (wr_addr),
		// scalar result sits in lane 0
		.wr_data    (wb_data[0])
	);

	reg_bank_2r1w #(
		.NB_COL (`OPF_BYTE_PER_REG * `OPF_HW_LANE),
		.word_t (opf_data_pkg::hw_lane_t)
	) vector_bank (
		.clk        (clk),
		.rd0_en     (vector_rd0_en),
		.rd0_addr   (src0_addr),
		.rd0_data   (vector_rd0),
		.rd1_en     (vector_rd1_en),
		.rd1_addr   (vector_src1_addr),
		.rd1_data   (vector_rd1),
		.wr_byte_en (vector_byte_en),
		.wr_addr    (wr_addr),
		.wr_data    (wb_data)
	);

endmodule

/* reg_bank_2r1w.sv */
`timescale 1ns/1ps

module reg_bank_2r1w #(
	parameter int NB_COL = 4,
	parameter type word_t = logic [31:0]
) (
	input  logic                     clk,
	input  logic                     rd0_en,
	input  opf_inst_pkg::bank_addr_t rd0_addr,
	output word_t                    rd0_data,
	input  logic                     rd1_en,
	input  opf_inst_pkg::bank_addr_t rd1_addr,
	output word_t                    rd1_data,
	input  logic [NB_COL-1:0]        wr_byte_en,
	input  opf_inst_pkg::bank_addr_t wr_addr,
	input  word_t                    wr_data
);

	localparam int WORD_W = $bits(word_t);
	localparam int COL_W = WORD_W / NB_COL;
	// one row per thread and register
	localparam int DEPTH = 2 ** $bits(opf_inst_pkg::bank_addr_t);

	// storage kept flat so columns are plain bit slices
	logic [WORD_W-1:0] mem [DEPTH];
	logic [WORD_W-1:0] wr_bits;

	assign wr_bits = wr_data;

	// byte column writes
	always_ff @(posedge clk) begin
		for (int c = 0; c < NB_COL; c++) begin
			if (wr_byte_en[c]) begin
				mem[wr_addr][c*COL_W +: COL_W] <= wr_bits[c*COL_W +: COL_W];
			end
		end
	end

	// registered reads, old contents on a same-edge write
	// output holds while the enable is low
	always_ff @(posedge clk) begin
		if (rd0_en) begin
			rd0_data <= word_t'(mem[rd0_addr]);
		end
		if (rd1_en) begin
			rd1_data <= word_t'(mem[rd1_addr]);
		end
	end

endmodule

/* opf_data_pkg.sv */
`include "opf_consts.svh"

package opf_data_pkg;

	// one scalar word, also one lane of a vector
	typedef logic [`OPF_REG_SIZE-1:0] register_t;

	// full vector register, lane 0 in the low bits
	typedef register_t [`OPF_HW_LANE-1:0] hw_lane_t;

	// one bit per lane
	typedef logic [`OPF_HW_LANE-1:0] lane_mask_t;

	// byte write enables of one word
	typedef logic [`OPF_BYTE_PER_REG-1:0] byte_en_t;

	// byte write enables of a whole vector
	// flattens to one bit per bank column
	typedef byte_en_t [`OPF_HW_LANE-1:0] lane_byte_en_t;

endpackage

/* opf_inst_pkg.sv */
`include "opf_consts.svh"

package opf_inst_pkg;

	// hardware thread number
	typedef logic [$clog2(`OPF_THREAD_NUMB)-1:0] thread_id_t;

	// register number inside one thread
	typedef logic [$clog2(`OPF_REG_NUMBER)-1:0] reg_addr_t;

	// bank row, thread in the upper bits
	typedef logic [$bits(thread_id_t)+$bits(reg_addr_t)-1:0] bank_addr_t;

	// destination bitmap, one bit per register
	typedef logic [`OPF_REG_NUMBER-1:0] scoreboard_t;

	// decoded instruction as it leaves the scheduler
	typedef struct packed {
		// fetch address of the instruction
		logic [`OPF_REG_SIZE-1:0] pc;
		// source register numbers
		reg_addr_t source0;
		reg_addr_t source1;
		// immediate, also the memory offset
		logic [`OPF_REG_SIZE-1:0] immediate;
		// source0 from the vector file
		logic is_source0_vectorial;
		// source1 from the vector file
		logic is_source1_vectorial;
		// operand 1 is the immediate
		logic is_source1_immediate;
		// lane mask read from the mask register
		logic mask_enable;
		// operand 0 becomes base plus immediate
		logic is_memory_access;
	} instruction_t;

endpackage

/* opf_consts.svh */
`ifndef OPF_CONSTS_SVH
`define OPF_CONSTS_SVH

// lanes per vector register
`define OPF_HW_LANE 8

// one register word in bits
`define OPF_REG_SIZE 32

// bytes per register word, one write enable each
`define OPF_BYTE_PER_REG 4

// registers visible to one thread
`define OPF_REG_NUMBER 64

// hardware threads sharing the banks
`define OPF_THREAD_NUMB 4

// fixed scalar register that holds the lane mask
// only the low lane bits of it are used
`define OPF_MASK_REG 60

// register number standing for the program counter
// never read from the banks as real data
`define OPF_PC_REG 63

`endif
